/* rtl/roce_params.svh */
`ifndef ROCE_PARAMS_SVH
`define ROCE_PARAMS_SVH

// payload stream geometry
`define ROCE_DATA_WIDTH 64
`define ROCE_BEAT_BYTES 8

// path mtu in bytes kept small so packets turn over quickly
`define ROCE_PMTU 256

// header sizes in bytes
`define ROCE_BTH_BYTES 12
`define ROCE_RETH_BYTES 16
`define ROCE_UDP_HDR_BYTES 8

// local endpoint
`define ROCE_LOC_IP 32'hD1D40116
`define ROCE_LOC_UDP_PORT 16'h0123

// well known RoCE v2 destination port
`define ROCE_UDP_PORT 16'd4791

// default partition
`define ROCE_P_KEY 16'hFFFF

`endif

/* rtl/roce_hdr_pkg.sv */
`default_nettype none

package roce_hdr_pkg;

  // BTH opcodes for RC RDMA WRITE
  typedef enum logic [7:0] {
    write_first  = 8'h06,
    write_middle = 8'h07,
    write_last   = 8'h08,
    write_only   = 8'h0A
  } opcode_e;

  // transport fields
  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;
  typedef logic [31:0] rkey_t;
  typedef logic [63:0] vaddr_t;

  // network fields
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_len_t;

  // message length in bytes
  typedef logic [31:0] dma_len_t;

endpackage

`default_nettype wire

/* rtl/roce_seg_pkg.sv */
`default_nettype none

`include "roce_params.svh"

package roce_seg_pkg;

  // which kind of packet the current beat belongs to
  typedef enum logic [2:0] {
    st_idle,
    st_only,
    st_first,
    st_middle,
    st_last
  } seg_state_e;

  // byte offset inside one packet
  typedef logic [13:0] pkt_bytes_t;

  typedef logic [`ROCE_DATA_WIDTH-1:0] beat_data_t;
  typedef logic [`ROCE_BEAT_BYTES-1:0] beat_keep_t;

endpackage

`default_nettype wire

/* rtl/roce_beat_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "roce_params.svh"

module roce_beat_tracker
  import roce_hdr_pkg::*, roce_seg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     s_tvalid,
  input  logic     s_tready,
  input  dma_len_t msg_len,
  output logic     beat_fire,
  output logic     msg_start,
  output logic     pkt_start,
  output logic     pkt_end,
  output logic     msg_end,
  output dma_len_t remaining
);

  localparam dma_len_t beat_len = dma_len_t'(`ROCE_BEAT_BYTES);
  localparam pkt_bytes_t pkt_step = pkt_bytes_t'(`ROCE_BEAT_BYTES);
  localparam pkt_bytes_t pkt_full = pkt_bytes_t'(`ROCE_PMTU);

  logic       in_msg;
  dma_len_t   rem_reg;
  pkt_bytes_t pkt_cnt;

  assign beat_fire = s_tvalid & s_tready;
  assign msg_start = beat_fire & ~in_msg;
  assign pkt_start = beat_fire & (pkt_cnt == '0);

  // bytes still to send including the beat being accepted
  assign remaining = in_msg ? rem_reg : msg_len;

  assign msg_end = beat_fire & (remaining <= beat_len);
  assign pkt_end = msg_end | (beat_fire & (pkt_cnt + pkt_step == pkt_full));

  always_ff @(posedge clk) begin
    if (rst) begin
      in_msg  <= 1'b0;
      pkt_cnt <= '0;
    end else if (beat_fire) begin
      in_msg  <= ~msg_end;
      pkt_cnt <= pkt_end ? '0 : pkt_cnt + pkt_step;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_fire) begin
      rem_reg <= remaining - beat_len;
    end
  end

endmodule

`default_nettype wire

/* rtl/roce_seg_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "roce_params.svh"

module roce_seg_fsm
  import roce_hdr_pkg::*, roce_seg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     beat_fire,
  input  logic     msg_start,
  input  logic     pkt_start,
  input  logic     pkt_end,
  input  logic     msg_end,
  input  dma_len_t remaining,
  input  psn_t     start_psn,
  output opcode_e  opcode,
  output psn_t     psn,
  output udp_len_t udp_len,
  output logic     has_reth
);

  localparam dma_len_t pmtu_len = dma_len_t'(`ROCE_PMTU);
  localparam udp_len_t full_payload = udp_len_t'(`ROCE_PMTU);
  localparam udp_len_t fixed_len = udp_len_t'(`ROCE_BTH_BYTES + `ROCE_UDP_HDR_BYTES);
  localparam udp_len_t reth_len = udp_len_t'(`ROCE_RETH_BYTES);

  seg_state_e state;
  seg_state_e pkt_state;
  psn_t       psn_reg;
  logic       fits;
  udp_len_t   payload_len;

  // the rest of the message fits in one packet
  assign fits = remaining <= pmtu_len;

  // packet kind is decided on its first beat and then held
  always_comb begin
    pkt_state = state;
    if (pkt_start) begin
      if (msg_start) begin
        pkt_state = fits ? st_only : st_first;
      end else begin
        pkt_state = fits ? st_last : st_middle;
      end
    end
  end

  always_comb begin
    case (pkt_state)
      st_first:  opcode = write_first;
      st_middle: opcode = write_middle;
      st_last:   opcode = write_last;
      default:   opcode = write_only;
    endcase
  end

  assign has_reth = (pkt_state == st_only) || (pkt_state == st_first);

  // only the first beat of a packet is used for the length
  assign payload_len = ((pkt_state == st_first) || (pkt_state == st_middle)) ?
                       full_payload : udp_len_t'(remaining);

  assign udp_len = payload_len + fixed_len + (has_reth ? reth_len : udp_len_t'(0));

  assign psn = msg_start ? start_psn : psn_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      psn_reg <= '0;
    end else if (beat_fire) begin
      state   <= msg_end ? st_idle : pkt_state;
      // psn wraps at 2^24 by width
      psn_reg <= pkt_end ? psn + psn_t'(1) : psn;
    end
  end

endmodule

`default_nettype wire

/* rtl/roce_tx_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_tx_stage
  import roce_hdr_pkg::*, roce_seg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  beat_data_t s_tdata,
  input  beat_keep_t s_tkeep,
  input  logic       s_tvalid,
  output logic       s_tready,
  input  logic       pkt_start,
  input  logic       pkt_end,
  input  opcode_e    opcode,
  input  psn_t       psn,
  input  udp_len_t   udp_len,
  input  logic       has_reth,
  output beat_data_t m_tdata,
  output beat_keep_t m_tkeep,
  output logic       m_tvalid,
  output logic       m_tlast,
  input  logic       m_tready,
  output logic       hdr_valid,
  output logic       reth_valid,
  output opcode_e    bth_opcode,
  output psn_t       bth_psn,
  output udp_len_t   udp_length
);

  logic load;
  logic first_reg;
  logic has_reth_reg;

  // one entry that accepts when empty or draining this cycle
  assign s_tready = ~m_tvalid | m_tready;
  assign load = s_tvalid & s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid <= 1'b0;
    end else if (s_tready) begin
      m_tvalid <= s_tvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_tdata   <= s_tdata;
      m_tkeep   <= s_tkeep;
      m_tlast   <= pkt_end;
      first_reg <= pkt_start;
    end
  end

  // header fields change only when a new packet enters
  always_ff @(posedge clk) begin
    if (load && pkt_start) begin
      bth_opcode   <= opcode;
      bth_psn      <= psn;
      udp_length   <= udp_len;
      has_reth_reg <= has_reth;
    end
  end

  assign hdr_valid  = m_tvalid & first_reg;
  assign reth_valid = hdr_valid & has_reth_reg;

endmodule

`default_nettype wire

/* rtl/roce_tx_header_producer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "roce_params.svh"

module roce_tx_header_producer
  import roce_hdr_pkg::*, roce_seg_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // payload in
  input  beat_data_t  s_tdata,
  input  beat_keep_t  s_tkeep,
  input  logic        s_tvalid,
  output logic        s_tready,
  // payload out
  output beat_data_t  m_tdata,
  output beat_keep_t  m_tkeep,
  output logic        m_tvalid,
  output logic        m_tlast,
  input  logic        m_tready,
  // per message settings
  input  qpn_t        dest_qp,
  input  psn_t        start_psn,
  input  vaddr_t      v_addr,
  input  rkey_t       r_key,
  input  dma_len_t    msg_len,
  input  ip_addr_t    dest_ip,
  // header fields
  output logic        hdr_valid,
  output logic        reth_valid,
  output opcode_e     bth_opcode,
  output psn_t        bth_psn,
  output qpn_t        bth_dest_qp,
  output logic [15:0] bth_p_key,
  output vaddr_t      reth_v_addr,
  output rkey_t       reth_r_key,
  output dma_len_t    reth_length,
  output ip_addr_t    ip_src,
  output ip_addr_t    ip_dest,
  output logic [15:0] udp_src_port,
  output logic [15:0] udp_dest_port,
  output udp_len_t    udp_length
);

  logic     beat_fire;
  logic     msg_start;
  logic     pkt_start;
  logic     pkt_end;
  logic     msg_end;
  dma_len_t remaining;
  opcode_e  opcode;
  psn_t     psn;
  udp_len_t udp_len;
  logic     has_reth;

  roce_beat_tracker u_tracker (
    .clk(clk), .rst(rst), .s_tvalid(s_tvalid), .s_tready(s_tready), .msg_len(msg_len),
    .beat_fire(beat_fire), .msg_start(msg_start), .pkt_start(pkt_start),
    .pkt_end(pkt_end), .msg_end(msg_end), .remaining(remaining)
  );

  roce_seg_fsm u_fsm (
    .clk(clk), .rst(rst), .beat_fire(beat_fire), .msg_start(msg_start),
    .pkt_start(pkt_start), .pkt_end(pkt_end), .msg_end(msg_end), .remaining(remaining),
    .start_psn(start_psn), .opcode(opcode), .psn(psn), .udp_len(udp_len),
    .has_reth(has_reth)
  );

  roce_tx_stage u_stage (
    .clk(clk), .rst(rst), .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
    .s_tready(s_tready), .pkt_start(pkt_start), .pkt_end(pkt_end), .opcode(opcode),
    .psn(psn), .udp_len(udp_len), .has_reth(has_reth), .m_tdata(m_tdata),
    .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tlast(m_tlast), .m_tready(m_tready),
    .hdr_valid(hdr_valid), .reth_valid(reth_valid), .bth_opcode(bth_opcode),
    .bth_psn(bth_psn), .udp_length(udp_length)
  );

  // settings are held by the source for the whole message
  assign bth_dest_qp = dest_qp;
  assign reth_v_addr = v_addr;
  assign reth_r_key  = r_key;
  assign reth_length = msg_len;
  assign ip_dest     = dest_ip;

  assign bth_p_key     = `ROCE_P_KEY;
  assign ip_src        = `ROCE_LOC_IP;
  assign udp_src_port  = `ROCE_LOC_UDP_PORT;
  assign udp_dest_port = `ROCE_UDP_PORT;

endmodule

`default_nettype wire

/* bench/roce_tx_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_tx_properties
  import roce_hdr_pkg::*, roce_seg_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       m_tvalid,
  input logic       m_tready,
  input logic       m_tlast,
  input beat_data_t m_tdata,
  input beat_keep_t m_tkeep,
  input logic       hdr_valid,
  input logic       reth_valid,
  input opcode_e    bth_opcode,
  input psn_t       bth_psn,
  input udp_len_t   udp_length
);

  int violations = 0;

  // high when the next output beat opens a packet
  logic pkt_first;

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_first <= 1'b1;
    end else if (m_tvalid && m_tready) begin
      pkt_first <= m_tlast;
    end
  end

  hdr_on_first_beat: assert property (@(posedge clk) disable iff (rst)
    (hdr_valid || m_tvalid) |-> (m_tvalid && (hdr_valid == pkt_first)))
    else begin
      violations++;
      $error("hdr_valid does not mark the first beat of a packet");
    end

  reth_on_reth_opcode: assert property (@(posedge clk) disable iff (rst)
    (reth_valid || hdr_valid) |->
      (hdr_valid && (reth_valid == (bth_opcode == write_first || bth_opcode == write_only))))
    else begin
      violations++;
      $error("reth_valid does not follow hdr_valid and the opcode");
    end

  // a stalled beat and its header keep still until taken
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tkeep) &&
      $stable(m_tlast) && $stable(hdr_valid) && $stable(reth_valid) &&
      $stable(bth_opcode) && $stable(bth_psn) && $stable(udp_length)))
    else begin
      violations++;
      $error("output changed while stalled");
    end

endmodule

bind roce_tx_header_producer roce_tx_properties u_props (
  .clk(clk), .rst(rst), .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast),
  .m_tdata(m_tdata), .m_tkeep(m_tkeep), .hdr_valid(hdr_valid), .reth_valid(reth_valid),
  .bth_opcode(bth_opcode), .bth_psn(bth_psn), .udp_length(udp_length)
);

`default_nettype wire

/* bench/roce_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "roce_params.svh"

module roce_tx_tb
  import roce_hdr_pkg::*, roce_seg_pkg::*;
();

  localparam int pmtu = `ROCE_PMTU;
  localparam int beat_bytes = `ROCE_BEAT_BYTES;
  // sum of every message length sent below
  localparam int total_bytes = 64 + 1000 + 512 + 1000 + 64 + 296 + 520;
  localparam int total_beats = total_bytes / beat_bytes;
  localparam int watchdog_cycles = total_beats * 20 + 500;

  logic        clk;
  logic        rst;
  beat_data_t  s_tdata;
  beat_keep_t  s_tkeep;
  logic        s_tvalid;
  logic        s_tready;
  beat_data_t  m_tdata;
  beat_keep_t  m_tkeep;
  logic        m_tvalid;
  logic        m_tlast;
  logic        m_tready = 1'b1;
  qpn_t        dest_qp;
  psn_t        start_psn;
  vaddr_t      v_addr;
  rkey_t       r_key;
  dma_len_t    msg_len;
  ip_addr_t    dest_ip;
  logic        hdr_valid;
  logic        reth_valid;
  opcode_e     bth_opcode;
  psn_t        bth_psn;
  qpn_t        bth_dest_qp;
  logic [15:0] bth_p_key;
  vaddr_t      reth_v_addr;
  rkey_t       reth_r_key;
  dma_len_t    reth_length;
  ip_addr_t    ip_src;
  ip_addr_t    ip_dest;
  logic [15:0] udp_src_port;
  logic [15:0] udp_dest_port;
  udp_len_t    udp_length;

  // expected packets and beats queued by the driver for the checker
  opcode_e    exp_op_q[$];
  psn_t       exp_psn_q[$];
  int         exp_udp_q[$];
  int         exp_beats_q[$];
  beat_data_t exp_data_q[$];

  qpn_t     exp_qp;
  vaddr_t   exp_vaddr;
  rkey_t    exp_rkey;
  dma_len_t exp_len;
  ip_addr_t exp_ip;

  opcode_e cur_op;
  psn_t    cur_psn;
  int      cur_udp;
  int      cur_beats;
  int      beat_in_pkt = 0;

  int    beats_queued = 0;
  int    beats_seen = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    err_mark = 0;
  int    bp_pct = 0;
  int    prop_fails;
  string test_name = "reset";

  roce_tx_header_producer uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // header and beat count of packet idx in a message of len bytes
  function automatic void ref_packet(input int len, input psn_t first_psn, input int idx,
                                     output opcode_e op, output psn_t psn, output int udp,
                                     output int beats);
    int npkt;
    int rem;
    int bytes;
    npkt = (len + pmtu - 1) / pmtu;
    rem = len - idx * pmtu;
    bytes = (rem > pmtu) ? pmtu : rem;
    if (npkt == 1) op = write_only;
    else if (idx == 0) op = write_first;
    else if (idx == npkt - 1) op = write_last;
    else op = write_middle;
    psn = first_psn + psn_t'(idx);
    udp = bytes + 12 + 8 + ((op == write_only || op == write_first) ? 16 : 0);
    beats = bytes / beat_bytes;
  endfunction

  task report_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    errors++;
  endtask

  task send_message(input int len, input psn_t first_psn, input qpn_t qp, input vaddr_t va,
                    input rkey_t rk, input ip_addr_t ip, input int gap_pct);
    int nbeats;
    int npkt;
    int sent;
    int i;
    opcode_e op;
    psn_t p;
    int udp;
    int beats;
    // the message inputs pass straight through and the previous message must drain first
    while (beats_queued != beats_seen) @(posedge clk);
    nbeats = len / beat_bytes;
    npkt = (len + pmtu - 1) / pmtu;
    for (i = 0; i < npkt; i++) begin
      ref_packet(len, first_psn, i, op, p, udp, beats);
      exp_op_q.push_back(op);
      exp_psn_q.push_back(p);
      exp_udp_q.push_back(udp);
      exp_beats_q.push_back(beats);
    end
    exp_qp = qp;
    exp_vaddr = va;
    exp_rkey = rk;
    exp_len = dma_len_t'(len);
    exp_ip = ip;
    beats_queued += nbeats;
    @(posedge clk);
    dest_qp <= qp;
    start_psn <= first_psn;
    v_addr <= va;
    r_key <= rk;
    msg_len <= dma_len_t'(len);
    dest_ip <= ip;
    s_tvalid <= 1'b0;
    sent = 0;
    while (sent < nbeats) begin
      @(posedge clk);
      if (s_tvalid && s_tready) begin
        exp_data_q.push_back(s_tdata);
        sent++;
      end
      if (!s_tvalid || s_tready) begin
        if (sent < nbeats && $urandom_range(99) >= gap_pct) begin
          s_tvalid <= 1'b1;
          s_tdata <= {$urandom, $urandom};
        end else begin
          s_tvalid <= 1'b0;
        end
      end
    end
  endtask

  task check_output_beat;
    logic exp_reth;
    logic exp_last;
    beat_data_t exp_data;
    checks++;
    if (exp_data_q.size() == 0) begin
      $display("error in %s: output beat arrived with nothing pending", test_name);
      errors++;
      return;
    end
    if (beat_in_pkt == 0) begin
      if (exp_op_q.size() == 0) begin
        $display("error in %s: packet started with no packet expected", test_name);
        errors++;
        return;
      end
      cur_op = exp_op_q.pop_front();
      cur_psn = exp_psn_q.pop_front();
      cur_udp = exp_udp_q.pop_front();
      cur_beats = exp_beats_q.pop_front();
      exp_reth = (cur_op == write_first) || (cur_op == write_only);
      if (hdr_valid !== 1'b1) report_mismatch("hdr_valid", 64'd1, 64'(hdr_valid));
      if (bth_opcode !== cur_op) report_mismatch("bth_opcode", 64'(cur_op), 64'(bth_opcode));
      if (bth_psn !== cur_psn) report_mismatch("bth_psn", 64'(cur_psn), 64'(bth_psn));
      if (udp_length !== udp_len_t'(cur_udp)) begin
        report_mismatch("udp_length", 64'(cur_udp), 64'(udp_length));
      end
      if (reth_valid !== exp_reth) report_mismatch("reth_valid", 64'(exp_reth), 64'(reth_valid));
      if (bth_dest_qp !== exp_qp) report_mismatch("bth_dest_qp", 64'(exp_qp), 64'(bth_dest_qp));
      if (bth_p_key !== 16'hFFFF) report_mismatch("bth_p_key", 64'hFFFF, 64'(bth_p_key));
      if (ip_src !== `ROCE_LOC_IP) report_mismatch("ip_src", 64'(`ROCE_LOC_IP), 64'(ip_src));
      if (ip_dest !== exp_ip) report_mismatch("ip_dest", 64'(exp_ip), 64'(ip_dest));
      if (udp_src_port !== `ROCE_LOC_UDP_PORT) begin
        report_mismatch("udp_src_port", 64'(`ROCE_LOC_UDP_PORT), 64'(udp_src_port));
      end
      if (udp_dest_port !== 16'd4791) begin
        report_mismatch("udp_dest_port", 64'd4791, 64'(udp_dest_port));
      end
      if (exp_reth) begin
        if (reth_v_addr !== exp_vaddr) report_mismatch("reth_v_addr", exp_vaddr, reth_v_addr);
        if (reth_r_key !== exp_rkey) report_mismatch("reth_r_key", 64'(exp_rkey), 64'(reth_r_key));
        if (reth_length !== exp_len) report_mismatch("reth_length", 64'(exp_len), 64'(reth_length));
      end
    end else if (hdr_valid !== 1'b0) begin
      report_mismatch("hdr_valid", 64'd0, 64'(hdr_valid));
    end
    exp_data = exp_data_q.pop_front();
    if (m_tdata !== exp_data) report_mismatch("m_tdata", exp_data, m_tdata);
    if (m_tkeep !== 8'hFF) report_mismatch("m_tkeep", 64'hFF, 64'(m_tkeep));
    exp_last = (beat_in_pkt == cur_beats - 1);
    if (m_tlast !== exp_last) report_mismatch("m_tlast", 64'(exp_last), 64'(m_tlast));
    if (exp_last) beat_in_pkt = 0;
    else beat_in_pkt++;
    beats_seen++;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      // the stage takes a beat whenever it is empty or draining
      if (s_tready !== (!m_tvalid || m_tready)) begin
        report_mismatch("s_tready", 64'(!m_tvalid || m_tready), 64'(s_tready));
      end
      if (m_tvalid && m_tready) check_output_beat();
    end
  end

  // sink side stalls
  always @(posedge clk) begin
    if (rst) m_tready <= 1'b1;
    else m_tready <= ($urandom_range(99) >= bp_pct);
  end

  task start_test(input string name);
    test_name = name;
    err_mark = errors;
  endtask

  task finish_test;
    while (beats_queued != beats_seen) @(posedge clk);
    repeat (2) @(posedge clk);
    tests++;
    $display("test %s: %0d error(s)", test_name, errors - err_mark);
  endtask

  initial begin
    void'($urandom(67988));
    rst <= 1'b1;
    s_tdata <= '0;
    s_tkeep <= '1;
    s_tvalid <= 1'b0;
    dest_qp <= '0;
    start_psn <= '0;
    v_addr <= '0;
    r_key <= '0;
    msg_len <= '0;
    dest_ip <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    start_test("single_only");
    send_message(64, 24'h000100, 24'h000011, 64'h0000_1000_0000_0000, 32'hCAFE0001,
                 32'h0A000002, 0);
    finish_test();

    start_test("four_packets");
    send_message(1000, 24'h000200, 24'h000012, 64'h0000_2000_0000_0040, 32'hCAFE0002,
                 32'h0A000003, 0);
    finish_test();

    start_test("psn_wrap");
    send_message(512, 24'hFFFFFF, 24'h000013, 64'h0000_3000_0000_0080, 32'hCAFE0003,
                 32'h0A000004, 0);
    finish_test();

    start_test("backpressure");
    bp_pct = 50;
    send_message(1000, 24'h123456, 24'h000014, 64'h0000_4000_0000_0100, 32'hCAFE0004,
                 32'h0A000005, 25);
    finish_test();

    start_test("back_to_back");
    bp_pct = 20;
    send_message(64, 24'h000010, 24'h0000A1, 64'h1111_0000_0000_0000, 32'h11110001,
                 32'hC0A80001, 10);
    send_message(296, 24'h7FFFFF, 24'h0000A2, 64'h2222_0000_0000_0008, 32'h22220002,
                 32'hC0A80002, 10);
    send_message(520, 24'h000300, 24'h0000A3, 64'h3333_0000_0000_0010, 32'h33330003,
                 32'hC0A80003, 10);
    finish_test();
    bp_pct = 0;

    prop_fails = uut.u_props.violations;
    $display("tests %0d, beats checked %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/roce_hdr_pkg.sv
rtl/roce_seg_pkg.sv
rtl/roce_beat_tracker.sv
rtl/roce_seg_fsm.sv
rtl/roce_tx_stage.sv
rtl/roce_tx_header_producer.sv
bench/roce_tx_properties.sv
bench/roce_tx_tb.sv

/* Makefile */
TOP := roce_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
